// File: rtl/lsu_pkg.sv
package lsu_pkg;

	localparam int rob_width = 4;
	localparam int data_width = 32;
	localparam int addr_width = 10; // word address, 1k words

	// queue depths, the indexing logic assumes these values
	localparam int n_agu = 2;
	localparam int n_lq = 2;
	localparam int n_sq = 4;

	// older-store count per load, 0 to n_sq
	localparam int sq_ptr_width = 3;

	// issue opcodes
	typedef enum logic [1:0] {
		op_lw, // base + offset
		op_sw,
		op_lwi, // absolute address in imm
		op_swi
	} mem_op_t;

	// which queue a station entry belongs to
	typedef enum logic {
		kind_load,
		kind_store
	} agu_kind_t;

endpackage

// File: rtl/agu_station.sv
`timescale 1ns/1ps

module agu_station import lsu_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic issue_accept,
	input  mem_op_t issue_op,
	input  logic base_valid,
	input  logic [rob_width-1:0] base_tag,
	input  logic [data_width-1:0] base_data,
	input  logic [data_width-1:0] imm,
	input  logic [$clog2(n_lq+1)-1:0] lq_count,
	input  logic [sq_ptr_width-1:0] sq_count,
	input  logic lq_pop,
	input  logic sq_pop,
	input  logic cdb_valid,
	input  logic [rob_width-1:0] cdb_tag,
	input  logic [data_width-1:0] cdb_data,
	output logic full,
	output logic addr_wr_valid,
	output agu_kind_t addr_wr_kind,
	output logic [sq_ptr_width-1:0] addr_wr_slot,
	output logic [addr_width-1:0] addr_wr_addr
);
	typedef struct packed {
		logic valid;
		agu_kind_t kind;
		logic [sq_ptr_width-1:0] slot; // index in target queue
		logic base_ok;
		logic [rob_width-1:0] tag;
		logic [data_width-1:0] base;
		logic [data_width-1:0] offset;
	} agu_entry_t;

	agu_entry_t ent [n_agu]; // packed from entry 0
	agu_entry_t upd [n_agu];
	agu_entry_t nxt [n_agu];
	agu_entry_t new_ent;
	logic [n_agu-1:0] ready;
	logic alloc;
	logic dispatch;
	logic sel;

	assign alloc = issue_accept && (issue_op == op_lw || issue_op == op_sw);

	always_comb begin
		new_ent.valid = alloc;
		new_ent.kind = issue_op == op_sw ? kind_store : kind_load;
		// slot the queue will hand out at this edge
		new_ent.slot = new_ent.kind == kind_load ? sq_ptr_width'(lq_count - lq_pop)
		                                         : sq_count - sq_pop;
		new_ent.base_ok = base_valid || (cdb_valid && cdb_tag == base_tag);
		new_ent.tag = base_tag;
		new_ent.base = base_valid ? base_data : cdb_data;
		new_ent.offset = imm;
	end

	always_comb begin
		for (int i = 0; i < n_agu; i++) begin
			upd[i] = ent[i];
			if (ent[i].kind == kind_load)
				upd[i].slot = ent[i].slot - lq_pop;
			else
				upd[i].slot = ent[i].slot - sq_pop;
			if (!ent[i].base_ok && cdb_valid && cdb_tag == ent[i].tag) begin
				upd[i].base_ok = 1'b1;
				upd[i].base = cdb_data;
			end
			ready[i] = ent[i].valid && ent[i].base_ok;
		end
	end

	assign dispatch = ready[0] || ready[1];
	assign sel = !ready[0]; // oldest ready entry wins
	assign addr_wr_valid = dispatch;
	assign addr_wr_kind = ent[sel].kind;
	assign addr_wr_slot = ent[sel].slot;
	assign addr_wr_addr = addr_width'(ent[sel].base + ent[sel].offset);

	// no room even after this cycle's dispatch
	assign full = ent[0].valid && ent[1].valid && !dispatch;

	always_comb begin
		nxt[0] = upd[0];
		nxt[1] = upd[1];
		if (dispatch) begin
			if (!sel)
				nxt[0] = upd[1];
			nxt[1].valid = 1'b0;
		end
		// append behind whatever remains
		if (!nxt[0].valid)
			nxt[0] = new_ent;
		else if (!nxt[1].valid)
			nxt[1] = new_ent;
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < n_agu; i++) begin
			if (reset)
				ent[i].valid <= 1'b0;
			else
				ent[i] <= nxt[i];
		end
	end

	// slot bookkeeping must stay inside the live part of the target queue
	assert property (@(posedge clk) disable iff (reset)
		addr_wr_valid |-> addr_wr_slot <
			(addr_wr_kind == kind_load ? sq_ptr_width'(lq_count) : sq_count));

endmodule

// File: rtl/load_queue.sv
`timescale 1ns/1ps

module load_queue import lsu_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic alloc,
	input  logic alloc_abs,
	input  logic [rob_width-1:0] alloc_tag,
	input  logic [addr_width-1:0] alloc_addr,
	input  logic addr_wr_valid,
	input  agu_kind_t addr_wr_kind,
	input  logic [sq_ptr_width-1:0] addr_wr_slot,
	input  logic [addr_width-1:0] addr_wr_addr,
	input  logic [sq_ptr_width-1:0] sq_count,
	input  logic sq_pop,
	input  logic [n_sq-1:0] sq_addr_ok,
	input  logic [n_sq-1:0] sq_data_ok,
	input  logic [n_sq-1:0][addr_width-1:0] sq_addr,
	input  logic [n_sq-1:0][data_width-1:0] sq_data,
	input  logic [data_width-1:0] mem_rdata,
	output logic [addr_width-1:0] mem_raddr,
	output logic result_valid,
	input  logic result_ready,
	output logic [rob_width-1:0] result_tag,
	output logic [data_width-1:0] result_data,
	output logic lq_pop,
	output logic [$clog2(n_lq+1)-1:0] lq_count
);
	logic [n_lq-1:0] addr_ok;
	logic [n_lq-1:0][addr_width-1:0] addr;
	logic [n_lq-1:0][rob_width-1:0] tag;
	logic [n_lq-1:0][sq_ptr_width-1:0] older; // stores ahead of this load
	logic [n_lq-1:0] upd_addr_ok;
	logic [n_lq-1:0][addr_width-1:0] upd_addr;
	logic [n_lq-1:0][sq_ptr_width-1:0] upd_older;
	logic [$clog2(n_lq+1)-1:0] alloc_pos;
	logic older_ready;
	logic fwd_hit;
	logic [data_width-1:0] fwd_data;

	always_comb begin
		for (int i = 0; i < n_lq; i++) begin
			upd_addr_ok[i] = addr_ok[i];
			upd_addr[i] = addr[i];
			upd_older[i] = older[i];
			if (sq_pop && older[i] != '0)
				upd_older[i] = older[i] - 1'b1;
			if (addr_wr_valid && addr_wr_kind == kind_load &&
			    addr_wr_slot == sq_ptr_width'(i)) begin
				upd_addr_ok[i] = 1'b1;
				upd_addr[i] = addr_wr_addr;
			end
		end
	end

	// head check against its older stores, last match is the youngest
	always_comb begin
		older_ready = 1'b1;
		fwd_hit = 1'b0;
		fwd_data = '0;
		for (int i = 0; i < n_sq; i++) begin
			if (sq_ptr_width'(i) < older[0]) begin
				if (!sq_addr_ok[i] || !sq_data_ok[i])
					older_ready = 1'b0;
				if (sq_addr[i] == addr[0]) begin
					fwd_hit = 1'b1;
					fwd_data = sq_data[i];
				end
			end
		end
	end

	assign result_valid = lq_count != '0 && addr_ok[0] && older_ready;
	assign result_tag = tag[0];
	assign result_data = fwd_hit ? fwd_data : mem_rdata;
	assign mem_raddr = addr[0];
	assign lq_pop = result_valid && result_ready;
	assign alloc_pos = lq_count - lq_pop;

	always_ff @(posedge clk) begin
		int src;
		if (reset)
			lq_count <= '0;
		else
			lq_count <= lq_count + alloc - lq_pop;
		for (int i = 0; i < n_lq; i++) begin
			src = (lq_pop && i < n_lq - 1) ? i + 1 : i;
			if (alloc && alloc_pos == ($clog2(n_lq+1))'(i)) begin
				tag[i] <= alloc_tag;
				addr_ok[i] <= alloc_abs; // register forms wait for the station
				addr[i] <= alloc_addr;
				older[i] <= sq_count - sq_pop;
			end else begin
				tag[i] <= tag[src];
				addr_ok[i] <= upd_addr_ok[src];
				addr[i] <= upd_addr[src];
				older[i] <= upd_older[src];
			end
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		result_valid && !result_ready |=>
			result_valid && $stable(result_tag) && $stable(result_data));

endmodule

// File: rtl/store_queue.sv
`timescale 1ns/1ps

module store_queue import lsu_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic alloc,
	input  logic alloc_abs,
	input  logic [addr_width-1:0] alloc_addr,
	input  logic sdata_valid,
	input  logic [rob_width-1:0] sdata_tag,
	input  logic [data_width-1:0] sdata_data,
	input  logic cdb_valid,
	input  logic [rob_width-1:0] cdb_tag,
	input  logic [data_width-1:0] cdb_data,
	input  logic addr_wr_valid,
	input  agu_kind_t addr_wr_kind,
	input  logic [sq_ptr_width-1:0] addr_wr_slot,
	input  logic [addr_width-1:0] addr_wr_addr,
	input  logic commit_valid,
	output logic commit_ready,
	output logic sq_pop,
	output logic [sq_ptr_width-1:0] sq_count,
	output logic [n_sq-1:0] sq_addr_ok,
	output logic [n_sq-1:0] sq_data_ok,
	output logic [n_sq-1:0][addr_width-1:0] sq_addr,
	output logic [n_sq-1:0][data_width-1:0] sq_data,
	output logic [addr_width-1:0] mem_waddr,
	output logic [data_width-1:0] mem_wdata
);
	logic [n_sq-1:0][rob_width-1:0] data_tag; // producer of pending data
	logic [n_sq-1:0] upd_addr_ok;
	logic [n_sq-1:0][addr_width-1:0] upd_addr;
	logic [n_sq-1:0] upd_data_ok;
	logic [n_sq-1:0][data_width-1:0] upd_data;
	logic [sq_ptr_width-1:0] alloc_pos;
	logic new_data_ok;
	logic [data_width-1:0] new_data;

	// data operand may arrive on the CDB in the issue cycle
	assign new_data_ok = sdata_valid || (cdb_valid && cdb_tag == sdata_tag);
	assign new_data = sdata_valid ? sdata_data : cdb_data;

	always_comb begin
		for (int i = 0; i < n_sq; i++) begin
			upd_addr_ok[i] = sq_addr_ok[i];
			upd_addr[i] = sq_addr[i];
			upd_data_ok[i] = sq_data_ok[i];
			upd_data[i] = sq_data[i];
			if (addr_wr_valid && addr_wr_kind == kind_store &&
			    addr_wr_slot == sq_ptr_width'(i)) begin
				upd_addr_ok[i] = 1'b1;
				upd_addr[i] = addr_wr_addr;
			end
			if (!sq_data_ok[i] && cdb_valid && cdb_tag == data_tag[i]) begin
				upd_data_ok[i] = 1'b1;
				upd_data[i] = cdb_data;
			end
		end
	end

	// head retires only once fully resolved
	assign commit_ready = sq_count != '0 && sq_addr_ok[0] && sq_data_ok[0];
	assign sq_pop = commit_valid && commit_ready;
	assign mem_waddr = sq_addr[0];
	assign mem_wdata = sq_data[0];
	assign alloc_pos = sq_count - sq_pop;

	always_ff @(posedge clk) begin
		int src;
		if (reset)
			sq_count <= '0;
		else
			sq_count <= sq_count + alloc - sq_pop;
		for (int i = 0; i < n_sq; i++) begin
			src = (sq_pop && i < n_sq - 1) ? i + 1 : i;
			if (alloc && alloc_pos == sq_ptr_width'(i)) begin
				sq_addr_ok[i] <= alloc_abs;
				sq_addr[i] <= alloc_addr;
				sq_data_ok[i] <= new_data_ok;
				sq_data[i] <= new_data;
				data_tag[i] <= sdata_tag;
			end else begin
				sq_addr_ok[i] <= upd_addr_ok[src];
				sq_addr[i] <= upd_addr[src];
				sq_data_ok[i] <= upd_data_ok[src];
				sq_data[i] <= upd_data[src];
				data_tag[i] <= data_tag[src];
			end
		end
	end

	// the ROB must never commit a store that was not issued here
	assert property (@(posedge clk) disable iff (reset)
		commit_valid |-> sq_count != '0);

endmodule

// File: rtl/data_mem.sv
`timescale 1ns/1ps

module data_mem import lsu_pkg::*; (
	input  logic clk,
	input  logic we,
	input  logic [addr_width-1:0] waddr,
	input  logic [data_width-1:0] wdata,
	input  logic [addr_width-1:0] raddr,
	output logic [data_width-1:0] rdata
);
	logic [data_width-1:0] mem [2**addr_width];

	initial begin
		for (int i = 0; i < 2**addr_width; i++)
			mem[i] = '0;
	end

	always_ff @(posedge clk) begin
		if (we)
			mem[waddr] <= wdata;
	end

	assign rdata = mem[raddr]; // async read, sees last edge's write

endmodule

// File: rtl/lsu.sv
`timescale 1ns/1ps

module lsu import lsu_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic issue_valid,
	output logic issue_ready,
	input  mem_op_t issue_op,
	input  logic [rob_width-1:0] issue_tag,
	input  logic base_valid,
	input  logic [rob_width-1:0] base_tag,
	input  logic [data_width-1:0] base_data,
	input  logic sdata_valid,
	input  logic [rob_width-1:0] sdata_tag,
	input  logic [data_width-1:0] sdata_data,
	input  logic [data_width-1:0] imm,
	input  logic cdb_valid,
	input  logic [rob_width-1:0] cdb_tag,
	input  logic [data_width-1:0] cdb_data,
	output logic result_valid,
	input  logic result_ready,
	output logic [rob_width-1:0] result_tag,
	output logic [data_width-1:0] result_data,
	input  logic commit_valid,
	output logic commit_ready
);
	logic active;
	logic issue_accept;
	logic op_load;
	logic op_abs;
	logic lq_room;
	logic sq_room;
	logic agu_full;
	logic addr_wr_valid;
	agu_kind_t addr_wr_kind;
	logic [sq_ptr_width-1:0] addr_wr_slot;
	logic [addr_width-1:0] addr_wr_addr;
	logic [$clog2(n_lq+1)-1:0] lq_count;
	logic [sq_ptr_width-1:0] sq_count;
	logic lq_pop;
	logic sq_pop;
	logic [n_sq-1:0] sq_addr_ok;
	logic [n_sq-1:0] sq_data_ok;
	logic [n_sq-1:0][addr_width-1:0] sq_addr;
	logic [n_sq-1:0][data_width-1:0] sq_data;
	logic [addr_width-1:0] mem_raddr;
	logic [data_width-1:0] mem_rdata;
	logic [addr_width-1:0] mem_waddr;
	logic [data_width-1:0] mem_wdata;

	// held low through reset, opens the cycle after release
	always_ff @(posedge clk) begin
		if (reset)
			active <= 1'b0;
		else
			active <= 1'b1;
	end

	assign op_load = issue_op == op_lw || issue_op == op_lwi;
	assign op_abs = issue_op == op_lwi || issue_op == op_swi;
	assign lq_room = lq_count < n_lq || lq_pop; // a pop frees its slot this edge
	assign sq_room = sq_count < n_sq || sq_pop;
	assign issue_ready = active && (op_abs || !agu_full) && (op_load ? lq_room : sq_room);
	assign issue_accept = issue_valid && issue_ready;

	agu_station u_agu (
		.clk(clk), .reset(reset),
		.issue_accept(issue_accept), .issue_op(issue_op),
		.base_valid(base_valid), .base_tag(base_tag), .base_data(base_data), .imm(imm),
		.lq_count(lq_count), .sq_count(sq_count), .lq_pop(lq_pop), .sq_pop(sq_pop),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data),
		.full(agu_full),
		.addr_wr_valid(addr_wr_valid), .addr_wr_kind(addr_wr_kind),
		.addr_wr_slot(addr_wr_slot), .addr_wr_addr(addr_wr_addr)
	);

	load_queue u_lq (
		.clk(clk), .reset(reset),
		.alloc(issue_accept && op_load), .alloc_abs(op_abs),
		.alloc_tag(issue_tag), .alloc_addr(imm[addr_width-1:0]),
		.addr_wr_valid(addr_wr_valid), .addr_wr_kind(addr_wr_kind),
		.addr_wr_slot(addr_wr_slot), .addr_wr_addr(addr_wr_addr),
		.sq_count(sq_count), .sq_pop(sq_pop),
		.sq_addr_ok(sq_addr_ok), .sq_data_ok(sq_data_ok), .sq_addr(sq_addr), .sq_data(sq_data),
		.mem_rdata(mem_rdata), .mem_raddr(mem_raddr),
		.result_valid(result_valid), .result_ready(result_ready),
		.result_tag(result_tag), .result_data(result_data),
		.lq_pop(lq_pop), .lq_count(lq_count)
	);

	store_queue u_sq (
		.clk(clk), .reset(reset),
		.alloc(issue_accept && !op_load), .alloc_abs(op_abs), .alloc_addr(imm[addr_width-1:0]),
		.sdata_valid(sdata_valid), .sdata_tag(sdata_tag), .sdata_data(sdata_data),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data),
		.addr_wr_valid(addr_wr_valid), .addr_wr_kind(addr_wr_kind),
		.addr_wr_slot(addr_wr_slot), .addr_wr_addr(addr_wr_addr),
		.commit_valid(commit_valid), .commit_ready(commit_ready),
		.sq_pop(sq_pop), .sq_count(sq_count),
		.sq_addr_ok(sq_addr_ok), .sq_data_ok(sq_data_ok), .sq_addr(sq_addr), .sq_data(sq_data),
		.mem_waddr(mem_waddr), .mem_wdata(mem_wdata)
	);

	data_mem u_mem (
		.clk(clk),
		.we(sq_pop), // committed head goes straight to memory
		.waddr(mem_waddr),
		.wdata(mem_wdata),
		.raddr(mem_raddr),
		.rdata(mem_rdata)
	);

endmodule

// File: verif/lsu_tests.svh
task automatic store_abs(input logic [addr_width-1:0] a, input logic [data_width-1:0] d,
		input logic dval, input logic [rob_width-1:0] dtag);
	pend_addr.push_back(a);
	pend_data.push_back(d);
	issue(op_swi, '0, 1'b1, '0, '0, dval, dtag, d, data_width'(a));
endtask

task automatic load_abs(input logic [rob_width-1:0] tag, input logic [addr_width-1:0] a);
	logic [data_width-1:0] exp;
	exp = expected_load(a);
	issue(op_lwi, tag, 1'b1, '0, '0, 1'b0, '0, '0, data_width'(a));
	wait_result(tag, exp);
endtask

task automatic abs_round_trip();
	store_abs(10'h040, $urandom, 1'b1, '0);
	commit_one();
	load_abs(4'd3, 10'h040);
	load_abs(4'd4, 10'h3c1); // never written so reads zero
endtask

task automatic reg_addressing();
	logic [data_width-1:0] d;
	d = $urandom;
	pend_addr.push_back(10'h123); // 0x100 + 0x23
	pend_data.push_back(d);
	issue(op_sw, '0, 1'b1, '0, 32'h100, 1'b1, '0, d, 32'h23);
	commit_one();
	issue(op_lw, 4'd5, 1'b1, '0, 32'h120, 1'b0, '0, '0, 32'h3); // same word
	wait_result(4'd5, expected_load(10'h123));
endtask

task automatic cdb_wakeup();
	logic [data_width-1:0] d;
	store_abs(10'h0a7, $urandom, 1'b1, '0); // preload the load target
	commit_one();
	issue(op_lw, 4'd6, 1'b0, 4'd9, '0, 1'b0, '0, '0, 32'h7);
	expect_quiet(4, 1'b1, 1'b0);
	broadcast(4'd9, 32'h0a0);
	wait_result(4'd6, expected_load(10'h0a7)); // 0xa0 + 0x7
	d = $urandom;
	store_abs(10'h155, d, 1'b0, 4'd10);
	expect_quiet(4, 1'b0, 1'b1);
	broadcast(4'd10, d);
	commit_one();
	load_abs(4'd7, 10'h155);
endtask

task automatic store_forwarding();
	store_abs(10'h2e0, $urandom, 1'b1, '0);
	store_abs(10'h2e0, $urandom, 1'b1, '0);
	load_abs(4'd8, 10'h2e0); // both stores still in the queue
	commit_one();
	commit_one();
	load_abs(4'd9, 10'h2e0);
endtask

task automatic load_disambiguation();
	logic [data_width-1:0] d;
	logic [data_width-1:0] exp;
	store_abs(10'h301, $urandom, 1'b1, '0);
	commit_one();
	d = $urandom;
	store_abs(10'h302, d, 1'b0, 4'd11);
	exp = expected_load(10'h301);
	issue(op_lwi, 4'd12, 1'b1, '0, '0, 1'b0, '0, '0, 32'h301);
	expect_quiet(4, 1'b1, 1'b1); // older store data unknown
	broadcast(4'd11, d);
	wait_result(4'd12, exp);
	commit_one();
endtask

task automatic back_pressure();
	logic [data_width-1:0] e1;
	logic [data_width-1:0] e2;
	result_ready = 1'b0;
	e1 = expected_load(10'h040);
	e2 = expected_load(10'h123);
	issue(op_lwi, 4'd13, 1'b1, '0, '0, 1'b0, '0, '0, 32'h040);
	issue(op_lwi, 4'd14, 1'b1, '0, '0, 1'b0, '0, '0, 32'h123);
	issue_op = op_lwi;
	repeat (3) begin
		#1;
		check("issue_ready", issue_ready, 1'b0);
		check("result_valid", result_valid, 1'b1);
		check("result_tag", result_tag, 4'd13);
		check("result_data", result_data, e1);
		next_cycle();
	end
	result_ready = 1'b1;
	wait_result(4'd13, e1);
	wait_result(4'd14, e2);
	for (int i = 0; i < n_sq; i++)
		store_abs(addr_width'(10'h380 + i), $urandom, 1'b1, '0);
	issue_op = op_swi;
	#1;
	check("issue_ready", issue_ready, 1'b0); // store queue full
	next_cycle();
	commit_one();
	#1;
	check("issue_ready", issue_ready, 1'b1);
	next_cycle();
	repeat (n_sq - 1)
		commit_one();
endtask

// File: verif/lsu_tb.sv
`timescale 1ns/1ps

module lsu_tb import lsu_pkg::*; ();
	localparam int timeout = 50; // cycles per wait

	logic clk = 1'b0;
	logic reset;
	logic issue_valid;
	logic issue_ready;
	mem_op_t issue_op;
	logic [rob_width-1:0] issue_tag;
	logic base_valid;
	logic [rob_width-1:0] base_tag;
	logic [data_width-1:0] base_data;
	logic sdata_valid;
	logic [rob_width-1:0] sdata_tag;
	logic [data_width-1:0] sdata_data;
	logic [data_width-1:0] imm;
	logic cdb_valid;
	logic [rob_width-1:0] cdb_tag;
	logic [data_width-1:0] cdb_data;
	logic result_valid;
	logic result_ready;
	logic [rob_width-1:0] result_tag;
	logic [data_width-1:0] result_data;
	logic commit_valid;
	logic commit_ready;

	int checks = 0;
	int errors = 0;
	logic [data_width-1:0] ref_mem [2**addr_width]; // committed memory image
	logic [addr_width-1:0] pend_addr [$]; // issued stores in age order
	logic [data_width-1:0] pend_data [$];

	always #5 clk = ~clk;

	lsu uut (.*);

	task automatic check(input string name, input logic [data_width-1:0] got,
			input logic [data_width-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("error at %0t ns: %s", $time, what);
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1; // drive point
	endtask

	task automatic issue(input mem_op_t op, input logic [rob_width-1:0] tag,
			input logic bval, input logic [rob_width-1:0] btag,
			input logic [data_width-1:0] bdata, input logic sval,
			input logic [rob_width-1:0] stag, input logic [data_width-1:0] sdata,
			input logic [data_width-1:0] offs);
		int n;
		n = 0;
		issue_op = op;
		issue_tag = tag;
		base_valid = bval;
		base_tag = btag;
		base_data = bdata;
		sdata_valid = sval;
		sdata_tag = stag;
		sdata_data = sdata;
		imm = offs;
		issue_valid = 1'b1;
		#1;
		while (!issue_ready && n < timeout) begin
			next_cycle();
			#1;
			n++;
		end
		if (!issue_ready)
			report_failure("issue was never accepted");
		next_cycle();
		issue_valid = 1'b0;
	endtask

	task automatic broadcast(input logic [rob_width-1:0] tag, input logic [data_width-1:0] data);
		cdb_valid = 1'b1;
		cdb_tag = tag;
		cdb_data = data;
		next_cycle();
		cdb_valid = 1'b0;
	endtask

	// retires the oldest store and updates the memory image
	task automatic commit_one();
		int n;
		logic [addr_width-1:0] a;
		n = 0;
		while (!commit_ready && n < timeout) begin
			next_cycle();
			n++;
		end
		if (!commit_ready || pend_addr.size() == 0) begin
			report_failure("commit_ready never rose for the oldest store");
			return;
		end
		commit_valid = 1'b1;
		a = pend_addr.pop_front();
		ref_mem[a] = pend_data.pop_front();
		next_cycle();
		commit_valid = 1'b0;
	endtask

	task automatic wait_result(input logic [rob_width-1:0] tag, input logic [data_width-1:0] exp);
		int n;
		n = 0;
		while (!result_valid && n < timeout) begin
			next_cycle();
			n++;
		end
		if (!result_valid) begin
			report_failure("load result never became valid");
		end else begin
			check("result_tag", result_tag, tag);
			check("result_data", result_data, exp);
		end
		next_cycle();
	endtask

	task automatic expect_quiet(input int cycles, input bit no_result, input bit no_commit);
		repeat (cycles) begin
			if (no_result)
				check("result_valid", result_valid, 1'b0);
			if (no_commit)
				check("commit_ready", commit_ready, 1'b0);
			next_cycle();
		end
	endtask

	// youngest pending store to the address wins over committed memory
	function automatic logic [data_width-1:0] expected_load(input logic [addr_width-1:0] a);
		logic [data_width-1:0] v;
		v = ref_mem[a];
		foreach (pend_addr[i])
			if (pend_addr[i] == a)
				v = pend_data[i];
		return v;
	endfunction

	`include "lsu_tests.svh"

	initial begin
		void'($urandom(85));
		foreach (ref_mem[i])
			ref_mem[i] = '0;
		reset = 1'b1;
		issue_valid = 1'b0;
		issue_op = op_lw;
		issue_tag = '0;
		base_valid = 1'b0;
		base_tag = '0;
		base_data = '0;
		sdata_valid = 1'b0;
		sdata_tag = '0;
		sdata_data = '0;
		imm = '0;
		cdb_valid = 1'b0;
		cdb_tag = '0;
		cdb_data = '0;
		result_ready = 1'b1;
		commit_valid = 1'b0;
		repeat (8) @(posedge clk);
		#1;
		check("issue_ready", issue_ready, 1'b0); // still in reset
		reset = 1'b0;
		next_cycle();
		check("result_valid", result_valid, 1'b0);
		check("commit_ready", commit_ready, 1'b0);
		abs_round_trip();
		reg_addressing();
		cdb_wakeup();
		store_forwarding();
		load_disambiguation();
		back_pressure();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// File: lsu.f
+incdir+verif
rtl/lsu_pkg.sv
rtl/agu_station.sv
rtl/load_queue.sv
rtl/store_queue.sv
rtl/data_mem.sv
rtl/lsu.sv
verif/lsu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= lsu_tb
RTL_TOP ?= lsu
FILELIST ?= lsu.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
LINT_FLAGS ?= --timing --assert
SIM_FLAGS ?= --timing --assert -Wno-fatal
FAIL_MSG ?= Finished with errors
PASS_MSG ?= Finished with no errors

SOURCES := $(wildcard rtl/*.sv verif/*.sv verif/*.svh)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(BUILD_DIR)/$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)

sim: $(BUILD_DIR)/$(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
